/* all.f */
+incdir+common
common/st_board_pkg.sv
common/st_bus_pkg.sv
verilog/boot_ctrl.sv
verilog/ikbd_inputs.sv
verilog/mem_map.sv
verilog/sd_arbiter.sv
verilog/st_glue_top.sv
testbench/st_glue_sva.sv
testbench/st_glue_tb.sv

/* common/st_board_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// board level types, chipset choice and boot sequencing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package st_board_pkg;

  // machine flavour as selected in the OSD
  typedef enum logic [1:0] {
    chip_st   = 2'd0,   // plain ST
    chip_mega = 2'd1,   // mega ST with blitter
    chip_ste  = 2'd2    // STE
  } chipset_e;

  // boot sequencer states
  typedef enum logic [1:0] {
    boot_hold    = 2'd0,   // just out of reset
    boot_wait_sd = 2'd1,   // waiting for image or timeout
    boot_run     = 2'd2    // card settled, cpu may run
  } boot_state_e;

  // system config from the control registers
  typedef struct packed {
    chipset_e chipset;
    logic     sys_reset;   // hold the ST in reset
    logic     coldboot;    // level, each rise wipes RAM
  } sys_cfg_t;

endpackage

/* common/st_bus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus request types between the ST chipset and board memory
// and between the disk controllers and the SD card port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package st_bus_pkg;

  // sector request from one disk controller
  // write data byte travels on its own port
  typedef struct packed {
    logic [1:0]  rd;    // read request per drive
    logic [1:0]  wr;    // write request per drive
    logic [31:0] lba;   // sector number
  } sector_req_t;

  // request as seen by the SD card controller
  typedef struct packed {
    logic [3:0]  rstart;    // acsi in 3:2, floppy in 1:0
    logic [3:0]  wstart;
    logic [31:0] lba;
    logic [7:0]  wr_byte;   // byte going to the card
  } card_req_t;

  // ST memory cycle towards SDRAM
  typedef struct packed {
    logic        ras_n;
    logic        cash_n;   // upper byte strobe
    logic        casl_n;   // lower byte strobe
    logic        we_n;
    logic [23:1] addr;     // word address
  } mem_req_t;

endpackage

/* common/st_glue_settings.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// build constants for the ST board glue layer
// include wherever sizes, boot timing or flash layout are needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef ST_GLUE_SETTINGS_SVH
`define ST_GLUE_SETTINGS_SVH

// keyboard matrix as scanned by the ikbd
`define st_kbd_rows 15   // row select lines
`define st_kbd_cols 8    // column return lines

// time given to the MCU to mount a default image
`define st_sd_wait_default 64000000   // 2 s at 32 MHz

// flash high address bits where the TOS images live
`define st_rom_base 4'b0010

// lowest word address bit touched by the cold boot scramble
`define st_scramble_lsb 3

`endif

/* run.sh */
#!/usr/bin/env bash
# build and run the glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f all.f --top-module st_glue_tb -o st_glue_sim

out="$(./obj_dir/st_glue_sim)"
echo "$out"

if echo "$out" | grep -qx "STATUS: PASS"; then
  exit 0
else
  exit 1
fi

/* testbench/st_glue_sva.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent checks on boot release and SD port steering
// bound into st_glue_top from this file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module st_glue_sva (
  input logic                    clk_32,
  input logic                    arst_n,
  input logic                    cpu_run,
  input logic                    sd_ready,
  input st_bus_pkg::sector_req_t acsi_req,
  input st_bus_pkg::card_req_t   card_req
);

  // the ST never leaves reset before the card settled
  run_needs_sd: assert property (@(posedge clk_32) disable iff (!arst_n)
    !(cpu_run && !sd_ready))
    else $error("cpu_run high while sd_ready low");

  // sd_ready is sticky until the next pll reset
  sd_ready_sticky: assert property (@(posedge clk_32) disable iff (!arst_n)
    sd_ready |=> sd_ready)
    else $error("sd_ready fell without reset");

  // live acsi read owns the sector number
  acsi_read_lba: assert property (@(posedge clk_32) disable iff (!arst_n)
    (acsi_req.rd != 2'b00) |-> (card_req.lba == acsi_req.lba))
    else $error("card lba not taken from acsi during acsi read");

endmodule

bind st_glue_top st_glue_sva u_sva (
  .clk_32   (clk_32),
  .arst_n   (arst_n),
  .cpu_run  (cpu_run),
  .sd_ready (sd_ready),
  .acsi_req (acsi_req),
  .card_req (card_req)
);

/* testbench/st_glue_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the ST board glue, random stimulus against a
// behavioural model, verdict on the last line
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "st_glue_settings.svh"

module st_glue_tb;

  localparam int sd_wait = 300;   // short card timeout for sim

  logic                                      clk_32;
  logic                                      arst_n;
  st_board_pkg::sys_cfg_t                    cfg;
  logic                                      reset_button;
  logic                                      ram_ready;
  logic                                      flash_ready;
  logic [31:0]                               img_size;
  st_bus_pkg::mem_req_t                      mem_req;
  logic                                      rom_n;
  logic [17:1]                               rom_addr;
  logic [`st_kbd_rows-1:0][`st_kbd_cols-1:0] kbd_rows;
  logic [`st_kbd_rows-1:0]                   kbd_select_n;
  logic [4:0]                                hid_joy1;
  logic [4:0]                                joy_pins_n;
  st_bus_pkg::sector_req_t                   fdc_req;
  st_bus_pkg::sector_req_t                   acsi_req;
  logic [7:0]                                fdc_wr_byte;
  logic [7:0]                                acsi_wr_byte;
  logic                                      cpu_run;
  logic                                      sd_ready;
  logic [1:0]                                scramble_key;
  logic [22:1]                               ram_addr_s;
  logic                                      ram_cs;
  logic                                      ram_we;
  logic [1:0]                                ds_n;
  logic                                      flash_cs;
  logic [22:0]                               flash_addr;
  logic [`st_kbd_cols-1:0]                   kbd_cols;
  logic [4:0]                                joy1;
  st_bus_pkg::card_req_t                     card_req;

  integer seed;
  int     err_bit, err_byte, err_addr, err_card, err_count, err_timeout;
  int     total;

  st_glue_top #(.sd_wait_cycles(sd_wait)) uut (.*);

  initial begin
    clk_32 = 1'b0;
    forever #20 clk_32 = ~clk_32;   // 25 MHz is close enough in sim
  end

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_bit++;
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      err_byte++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_mem_addr(input string name, input logic [22:1] exp,
                                input logic [22:1] act);
    if (act !== exp) begin
      err_addr++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flash_addr(input string name, input logic [22:0] exp,
                                  input logic [22:0] act);
    if (act !== exp) begin
      err_addr++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_card_req(input string name, input st_bus_pkg::card_req_t exp,
                                input st_bus_pkg::card_req_t act);
    if (act !== exp) begin
      err_card++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      err_count++;
      $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // quiet board, memories up, no requests
  task automatic init_inputs;
    arst_n       <= 1'b0;
    cfg          <= '0;
    reset_button <= 1'b0;
    ram_ready    <= 1'b1;
    flash_ready  <= 1'b1;
    img_size     <= '0;
    mem_req      <= '1;   // all strobes idle high
    rom_n        <= 1'b1;
    rom_addr     <= '0;
    kbd_rows     <= '1;
    kbd_select_n <= '1;
    hid_joy1     <= '0;
    joy_pins_n   <= '1;
    fdc_req      <= '0;
    acsi_req     <= '0;
    fdc_wr_byte  <= '0;
    acsi_wr_byte <= '0;
  endtask

  task automatic apply_reset;
    @(posedge clk_32);
    init_inputs;
    repeat (16) @(posedge clk_32);
    arst_n <= 1'b1;
  endtask

  // no image, card wait runs out, then gate cpu_run at random
  task automatic boot_timeout;
    int         cyc;
    int         i;
    logic [5:0] r;
    logic       exp_run;
    cyc = 0;
    while (!sd_ready && cyc < 4 * sd_wait) begin
      @(posedge clk_32);
      cyc++;
      @(negedge clk_32);
      check_bit("boot sd_ready", cyc >= sd_wait + 2, sd_ready);
      check_bit("boot cpu_run", cyc >= sd_wait + 2, cpu_run);
    end
    if (!sd_ready) begin
      err_timeout++;
      $display("Timeout: sd_ready did not rise after the card wait");
    end else begin
      check_count("boot timeout cycles", sd_wait + 2, cyc);
    end
    for (i = 0; i < 64; i++) begin
      @(posedge clk_32);
      r = 6'($random(seed));
      reset_button  <= r[0];
      cfg.sys_reset <= r[1];
      ram_ready     <= r[2] | r[3];   // mostly ready
      flash_ready   <= r[4] | r[5];
      exp_run = !r[0] && !r[1] && (r[2] | r[3]) && (r[4] | r[5]);
      @(negedge clk_32);
      check_bit("cpu_run gating", exp_run, cpu_run);
      check_bit("sd_ready held", 1'b1, sd_ready);
    end
  endtask

  // image appears before the timeout
  task automatic boot_by_image;
    int delay;
    apply_reset;
    delay = 2 + (($random(seed) & 32'h7fffffff) % (sd_wait - 10));
    repeat (delay) @(posedge clk_32);
    img_size <= 32'($random(seed)) | 32'd1;
    @(negedge clk_32);
    check_bit("image sd_ready early", 1'b0, sd_ready);
    @(posedge clk_32);
    @(negedge clk_32);
    check_bit("image sd_ready", 1'b1, sd_ready);
    check_bit("image cpu_run", 1'b1, cpu_run);
  endtask

  task automatic kbd_joy;
    logic [`st_kbd_rows-1:0][`st_kbd_cols-1:0] rows_v;
    logic [`st_kbd_rows-1:0]                   sel;
    logic [7:0]                                exp_cols;
    logic [4:0]                                hid;
    logic [4:0]                                pins;
    int                                        i;
    int                                        r;
    for (i = 0; i < 200; i++) begin
      for (r = 0; r < `st_kbd_rows; r++)
        rows_v[r] = 8'($random(seed) | $random(seed) | $random(seed));   // few keys down
      sel = 15'($random(seed));
      if (i % 10 == 0)
        sel = '1;                        // ikbd scans nothing
      else if (i % 10 == 5)
        sel = ~(15'd1 << (i % 15));      // one row only
      hid  = 5'($random(seed));
      pins = 5'($random(seed));
      exp_cols = 8'hff;
      for (r = 0; r < `st_kbd_rows; r++)
        if (sel[r] == 1'b0) exp_cols = exp_cols & rows_v[r];
      @(posedge clk_32);
      kbd_rows     <= rows_v;
      kbd_select_n <= sel;
      hid_joy1     <= hid;
      joy_pins_n   <= pins;
      @(negedge clk_32);
      check_byte("kbd_cols", exp_cols, kbd_cols);
      check_byte("joy1", {3'b000, hid | ~pins}, {3'b000, joy1});
    end
  endtask

  task automatic mem_map_check;
    logic [1:0]             key;      // coldboot rises seen, mod 4
    logic                   cb;
    logic                   cb_prev;
    st_bus_pkg::mem_req_t   req;
    logic                   rn;
    logic [17:1]            ra;
    st_board_pkg::chipset_e cs;
    int                     sel3;
    logic [22:1]            exp_ram;
    logic [22:0]            exp_flash;
    int                     i;
    key     = 2'd0;
    cb_prev = 1'b0;
    for (i = 0; i < 80; i++) begin
      cb = 1'($random(seed));
      if (cb && !cb_prev) key = key + 2'd1;
      req  = 27'({$random(seed), $random(seed)});
      rn   = 1'($random(seed));
      ra   = 17'($random(seed));
      sel3 = ($random(seed) & 32'hff) % 3;
      cs   = st_board_pkg::chipset_e'(2'(sel3));
      exp_ram   = req.addr[22:1] ^ (22'(key) << (`st_scramble_lsb - 1));
      exp_flash = (23'(`st_rom_base) << 19) | (23'(ra) << 1) |
                  ((cs == st_board_pkg::chip_ste) ? 23'h04_0000 : 23'h0);   // STE image
      @(posedge clk_32);
      mem_req      <= req;
      rom_n        <= rn;
      rom_addr     <= ra;
      cfg.chipset  <= cs;
      cfg.coldboot <= cb;
      repeat (2) @(posedge clk_32);   // key settles one edge later
      @(negedge clk_32);
      check_byte("scramble_key", {6'b000000, key}, {6'b000000, scramble_key});
      check_mem_addr("ram_addr_s", exp_ram, ram_addr_s);
      check_bit("ram_cs", !req.ras_n && !req.addr[23], ram_cs);
      check_bit("ram_we", !req.we_n, ram_we);
      check_bit("ds_n upper", req.cash_n, ds_n[1]);
      check_bit("ds_n lower", req.casl_n, ds_n[0]);
      check_bit("flash_cs", !rn, flash_cs);
      check_flash_addr("flash_addr", exp_flash, flash_addr);
      cb_prev = cb;
    end
  endtask

  task automatic sector_arb;
    st_bus_pkg::sector_req_t f;
    st_bus_pkg::sector_req_t a;
    st_bus_pkg::card_req_t   exp;
    logic [7:0]              fb;
    logic [7:0]              ab;
    logic [11:0]             r;
    logic                    fa;
    logic                    aa;
    logic                    last_m;   // model of the source memory
    int                      i;
    last_m = 1'b0;
    for (i = 0; i < 300; i++) begin
      r = 12'($random(seed));
      f.rd = 2'b00;
      f.wr = 2'b00;
      f.lba = $random(seed);
      a.rd = 2'b00;
      a.wr = 2'b00;
      a.lba = $random(seed);
      fb = 8'($random(seed));
      ab = 8'($random(seed));
      // 0,1 floppy  2,3 acsi  4 both  rest idle
      if (r[2:0] inside {3'd0, 3'd1, 3'd4}) begin
        f.rd = r[4:3];
        f.wr = r[6:5];
        if ({f.rd, f.wr} == 4'b0000) f.rd = 2'b01;
      end
      if (r[2:0] inside {3'd2, 3'd3, 3'd4}) begin
        a.rd = r[8:7];
        a.wr = r[10:9];
        if ({a.rd, a.wr} == 4'b0000) a.wr = 2'b10;
      end
      fa = (f.rd != 2'b00) || (f.wr != 2'b00);
      aa = (a.rd != 2'b00) || (a.wr != 2'b00);
      exp.rstart  = {a.rd, f.rd};
      exp.wstart  = {a.wr, f.wr};
      exp.lba     = (aa || last_m) ? a.lba : f.lba;
      exp.wr_byte = (aa || last_m) ? ab : fb;
      @(posedge clk_32);
      fdc_req      <= f;
      acsi_req     <= a;
      fdc_wr_byte  <= fb;
      acsi_wr_byte <= ab;
      @(negedge clk_32);
      check_card_req("card_req", exp, card_req);
      if (fa)
        last_m = 1'b0;   // floppy clears, even alongside acsi
      else if (aa)
        last_m = 1'b1;
    end
  endtask

  initial begin
    seed        = 32'h4fc95df4;
    err_bit     = 0;
    err_byte    = 0;
    err_addr    = 0;
    err_card    = 0;
    err_count   = 0;
    err_timeout = 0;
    init_inputs;
    apply_reset;
    boot_timeout;
    boot_by_image;
    kbd_joy;
    mem_map_check;
    sector_arb;
    repeat (4) @(posedge clk_32);
    total = err_bit + err_byte + err_addr + err_card + err_count + err_timeout;
    $display("errors: bit %0d byte %0d addr %0d card %0d count %0d timeout %0d",
             err_bit, err_byte, err_addr, err_card, err_count, err_timeout);
    if (total == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* verilog/boot_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// boot sequencer, holds the ST in reset until memories and
// SD card are up, and rolls the RAM scramble key on cold boot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "st_glue_settings.svh"

module boot_ctrl #(
  parameter int sd_wait_cycles = `st_sd_wait_default   // clocks before giving up on the card
) (
  input  logic                   clk_32,
  input  logic                   arst_n,        // pll lock
  input  st_board_pkg::sys_cfg_t cfg,
  input  logic                   reset_button,
  input  logic                   ram_ready,
  input  logic                   flash_ready,
  input  logic [31:0]            img_size,      // nonzero once MCU mounted an image
  output logic                   cpu_run,       // ST resb
  output logic                   sd_ready,
  output logic [1:0]             scramble_key
);

  st_board_pkg::boot_state_e state;
  logic [31:0]               wait_cnt;     // clocks spent in boot_wait_sd
  logic                      coldboot_d;   // previous coldboot level

  // boot sequencer
  always_ff @(posedge clk_32 or negedge arst_n) begin
    if (!arst_n) begin
      state    <= st_board_pkg::boot_hold;
      wait_cnt <= '0;
      sd_ready <= 1'b0;
    end else begin
      case (state)
        st_board_pkg::boot_hold: begin
          wait_cnt <= '0;
          state    <= st_board_pkg::boot_wait_sd;   // one cycle only
        end
        st_board_pkg::boot_wait_sd: begin
          // image mounted, or MCU had its chance
          if (img_size != 32'd0 || wait_cnt == 32'(sd_wait_cycles)) begin
            sd_ready <= 1'b1;
            state    <= st_board_pkg::boot_run;
          end else begin
            wait_cnt <= wait_cnt + 32'd1;
          end
        end
        st_board_pkg::boot_run: begin
          sd_ready <= 1'b1;   // sticky until next pll reset
        end
        default: begin
          state <= st_board_pkg::boot_hold;
        end
      endcase
    end
  end

  // every cold boot moves RAM lines 4:3 around
  // so stale contents look like garbage to TOS
  always_ff @(posedge clk_32 or negedge arst_n) begin
    if (!arst_n) begin
      coldboot_d   <= 1'b0;
      scramble_key <= 2'd0;
    end else begin
      coldboot_d <= cfg.coldboot;
      if (cfg.coldboot && !coldboot_d)
        scramble_key <= scramble_key + 2'd1;   // rising edge only
    end
  end

  // ST reset release, any one of these holds the cpu
  assign cpu_run = sd_ready && ram_ready && flash_ready &&
                   !cfg.sys_reset && !reset_button;

endmodule

/* verilog/ikbd_inputs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// keyboard matrix and joystick 1 as seen by the ikbd
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "st_glue_settings.svh"

module ikbd_inputs (
  input  logic [`st_kbd_rows-1:0][`st_kbd_cols-1:0] kbd_rows,   // from HID, low = key down
  input  logic [`st_kbd_rows-1:0]                   kbd_select_n,   // row drive from the ikbd
  input  logic [4:0]                                hid_joy1,   // MCU joystick, high active
  input  logic [4:0]                                joy_pins_n, // board pins, low active
  output logic [`st_kbd_cols-1:0]                   kbd_cols,
  output logic [4:0]                                joy1
);

  // wired-AND matrix
  // each driven row pulls its pressed columns low
  always_comb begin
    kbd_cols = '1;   // idle lines float high
    for (int r = 0; r < `st_kbd_rows; r++) begin
      if (!kbd_select_n[r])
        kbd_cols = kbd_cols & kbd_rows[r];
    end
  end

  // either source may press a direction or fire
  assign joy1 = hid_joy1 | ~joy_pins_n;

endmodule

/* verilog/mem_map.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ST memory map onto board SDRAM and SPI flash
// RAM address scramble, SDRAM strobes, ROM window relocation
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "st_glue_settings.svh"

module mem_map (
  input  st_bus_pkg::mem_req_t   mem_req,        // ST RAM cycle
  input  logic [1:0]             scramble_key,   // from boot_ctrl
  input  st_board_pkg::chipset_e chipset,
  input  logic                   rom_n,          // ST ROM select
  input  logic [17:1]            rom_addr,       // word address inside TOS
  output logic [22:1]            ram_addr_s,     // scrambled SDRAM word address
  output logic                   ram_cs,
  output logic                   ram_we,
  output logic [1:0]             ds_n,           // upper, lower
  output logic                   flash_cs,
  output logic [22:0]            flash_addr      // byte address in flash
);

  // flip two low word lines with the cold boot key
  always_comb begin
    ram_addr_s = mem_req.addr[22:1];
    ram_addr_s[`st_scramble_lsb +: 2] = mem_req.addr[`st_scramble_lsb +: 2] ^ scramble_key;
  end

  // 8MB of SDRAM, top half of the ST space is not RAM
  assign ram_cs = !mem_req.ras_n && !mem_req.addr[23];
  assign ram_we = !mem_req.we_n;
  assign ds_n   = {mem_req.cash_n, mem_req.casl_n};

  // TOS expected at $fc0000, stored at $100000 for ST and mega
  // and at $140000 for STE
  assign flash_cs   = !rom_n;
  assign flash_addr = {`st_rom_base,
                       chipset == st_board_pkg::chip_ste,   // second image
                       rom_addr,
                       1'b0};                               // words only

endmodule

/* verilog/sd_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shares the SD card sector port between floppy and ACSI
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module sd_arbiter (
  input  logic                    clk_32,
  input  logic                    arst_n,
  input  st_bus_pkg::sector_req_t fdc_req,        // floppy controller
  input  st_bus_pkg::sector_req_t acsi_req,       // hard disk
  input  logic [7:0]              fdc_wr_byte,
  input  logic [7:0]              acsi_wr_byte,
  output st_bus_pkg::card_req_t   card_req
);

  logic fdc_act;    // floppy asks this cycle
  logic acsi_act;   // acsi asks this cycle
  logic acsi_last;  // last request seen came from acsi
  logic is_acsi;    // data path owner

  assign fdc_act  = (fdc_req.rd != 2'b00) || (fdc_req.wr != 2'b00);
  assign acsi_act = (acsi_req.rd != 2'b00) || (acsi_req.wr != 2'b00);

  // remember the requester so lba and write data stay put
  // while the card is still busy after the request drops
  always_ff @(posedge clk_32 or negedge arst_n) begin
    if (!arst_n) begin
      acsi_last <= 1'b0;
    end else begin
      if (fdc_act)
        acsi_last <= 1'b0;   // floppy wins the memory
      else if (acsi_act)
        acsi_last <= 1'b1;
    end
  end

  assign is_acsi = acsi_act || acsi_last;   // live acsi request always steers

  // start bits go straight through, controller tells them apart
  assign card_req.rstart  = {acsi_req.rd, fdc_req.rd};
  assign card_req.wstart  = {acsi_req.wr, fdc_req.wr};
  assign card_req.lba     = is_acsi ? acsi_req.lba : fdc_req.lba;
  assign card_req.wr_byte = is_acsi ? acsi_wr_byte : fdc_wr_byte;

endmodule

/* verilog/st_glue_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// board glue between ST chipset and board peripherals
// arst_n is the pll lock, outputs feed the board controllers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "st_glue_settings.svh"

module st_glue_top #(
  parameter int sd_wait_cycles = `st_sd_wait_default
) (
  input  logic                                      clk_32,
  input  logic                                      arst_n,
  input  st_board_pkg::sys_cfg_t                    cfg,
  input  logic                                      reset_button,
  input  logic                                      ram_ready,
  input  logic                                      flash_ready,
  input  logic [31:0]                               img_size,
  input  st_bus_pkg::mem_req_t                      mem_req,
  input  logic                                      rom_n,
  input  logic [17:1]                               rom_addr,
  input  logic [`st_kbd_rows-1:0][`st_kbd_cols-1:0] kbd_rows,
  input  logic [`st_kbd_rows-1:0]                   kbd_select_n,
  input  logic [4:0]                                hid_joy1,
  input  logic [4:0]                                joy_pins_n,
  input  st_bus_pkg::sector_req_t                   fdc_req,
  input  st_bus_pkg::sector_req_t                   acsi_req,
  input  logic [7:0]                                fdc_wr_byte,
  input  logic [7:0]                                acsi_wr_byte,
  output logic                                      cpu_run,
  output logic                                      sd_ready,
  output logic [1:0]                                scramble_key,
  output logic [22:1]                               ram_addr_s,
  output logic                                      ram_cs,
  output logic                                      ram_we,
  output logic [1:0]                                ds_n,
  output logic                                      flash_cs,
  output logic [22:0]                               flash_addr,
  output logic [`st_kbd_cols-1:0]                   kbd_cols,
  output logic [4:0]                                joy1,
  output st_bus_pkg::card_req_t                     card_req
);

  // reset release and cold boot key
  boot_ctrl #(
    .sd_wait_cycles(sd_wait_cycles)
  ) u_boot_ctrl (
    .clk_32       (clk_32),
    .arst_n       (arst_n),
    .cfg          (cfg),
    .reset_button (reset_button),
    .ram_ready    (ram_ready),
    .flash_ready  (flash_ready),
    .img_size     (img_size),
    .cpu_run      (cpu_run),
    .sd_ready     (sd_ready),
    .scramble_key (scramble_key)
  );

  ikbd_inputs u_ikbd_inputs (
    .kbd_rows     (kbd_rows),
    .kbd_select_n (kbd_select_n),
    .hid_joy1     (hid_joy1),
    .joy_pins_n   (joy_pins_n),
    .kbd_cols     (kbd_cols),
    .joy1         (joy1)
  );

  mem_map u_mem_map (
    .mem_req      (mem_req),
    .scramble_key (scramble_key),
    .chipset      (cfg.chipset),   // rom image choice
    .rom_n        (rom_n),
    .rom_addr     (rom_addr),
    .ram_addr_s   (ram_addr_s),
    .ram_cs       (ram_cs),
    .ram_we       (ram_we),
    .ds_n         (ds_n),
    .flash_cs     (flash_cs),
    .flash_addr   (flash_addr)
  );

  // one card port for both disk controllers
  sd_arbiter u_sd_arbiter (
    .clk_32       (clk_32),
    .arst_n       (arst_n),
    .fdc_req      (fdc_req),
    .acsi_req     (acsi_req),
    .fdc_wr_byte  (fdc_wr_byte),
    .acsi_wr_byte (acsi_wr_byte),
    .card_req     (card_req)
  );

endmodule
